// ==== common/palette_pkg.sv ====
package palette_pkg;

    // colour prom geometry
    localparam int PROM_AW = 8;
    localparam int PROM_DW = 8;
    localparam int PROM_DEPTH = 1 << PROM_AW;

    // download bus
    localparam int IOCTL_AW = 16;

    // first download address of the prom window
    localparam logic [IOCTL_AW-1:0] PROM_START = 16'h0400;

    // output channel width
    localparam int COLOR_W = 8;

    // RRRGGGBB field layout inside one prom byte
    localparam int RED_W = 3;
    localparam int GRN_W = 3;
    localparam int BLU_W = 2;
    localparam int BLU_LSB = 0;
    localparam int GRN_LSB = BLU_LSB + BLU_W;
    localparam int RED_LSB = GRN_LSB + GRN_W;

    typedef logic [PROM_AW-1:0] prom_addr_t;
    typedef logic [PROM_DW-1:0] prom_data_t;
    typedef logic [IOCTL_AW-1:0] ioctl_addr_t;
    typedef logic [COLOR_W-1:0] color_t;

    // byte counter holds 0 to PROM_DEPTH
    typedef logic [PROM_AW:0] byte_count_t;

    // loader status
    typedef enum logic [1:0] {
        LOAD_IDLE = 2'd0,
        LOAD_BUSY = 2'd1,
        LOAD_DONE = 2'd2,
        LOAD_FAIL = 2'd3
    } load_state_t;

endpackage

// ==== source/palette_loader.sv ====
module palette_loader (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     dwnld,
    input  logic                     ioctl_wr,
    input  palette_pkg::ioctl_addr_t ioctl_addr,
    input  palette_pkg::prom_data_t  ioctl_dout,
    output logic                     prom_we,
    output palette_pkg::prom_addr_t  prom_wr_addr,
    output palette_pkg::prom_data_t  prom_wr_data,
    output logic                     prom_ready,
    output logic                     load_error
);

    palette_pkg::load_state_t  state;
    palette_pkg::byte_count_t  byte_count;
    palette_pkg::ioctl_addr_t  offset;
    logic                      in_window;
    logic                      accept;
    logic                      dwnld_rise;
    logic                      count_full;

    // offset wraps below PROM_START, so one compare covers both ends
    assign offset = ioctl_addr - palette_pkg::PROM_START;
    assign in_window = offset < palette_pkg::IOCTL_AW'(palette_pkg::PROM_DEPTH);

    // strobes only count while the download level is up
    assign accept = dwnld && ioctl_wr && in_window;

    // any state other than busy sees a new download start
    assign dwnld_rise = dwnld && (state != palette_pkg::LOAD_BUSY);

    assign count_full =
        byte_count == palette_pkg::byte_count_t'(palette_pkg::PROM_DEPTH);

    // state machine follows dwnld
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= palette_pkg::LOAD_IDLE;
        end else if (dwnld_rise) begin
            state <= palette_pkg::LOAD_BUSY;
        end else if (state == palette_pkg::LOAD_BUSY && !dwnld) begin
            // count already holds the strobe of the last high cycle
            state <= count_full ? palette_pkg::LOAD_DONE : palette_pkg::LOAD_FAIL;
        end
    end

    // saturating count of in-window strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            byte_count <= '0;
        end else if (dwnld_rise) begin
            // a strobe may arrive together with the rising level
            byte_count <= accept ? palette_pkg::byte_count_t'(1) : '0;
        end else if (accept && !count_full) begin
            byte_count <= byte_count + 1'b1;
        end
    end

    // write strobe, one cycle after ioctl_wr
    always_ff @(posedge clk) begin
        if (reset) begin
            prom_we <= 1'b0;
        end else begin
            prom_we <= accept;
        end
    end

    // write address and byte
    always_ff @(posedge clk) begin
        if (accept) begin
            prom_wr_addr <= offset[palette_pkg::PROM_AW-1:0];
            prom_wr_data <= ioctl_dout;
        end
    end

    // status levels straight from the state
    assign prom_ready = state == palette_pkg::LOAD_DONE;
    assign load_error = state == palette_pkg::LOAD_FAIL;

endmodule

// ==== video/palette_prom.sv ====
module palette_prom (
    input  logic                    clk,
    input  logic                    cen,
    input  palette_pkg::prom_data_t data,
    input  palette_pkg::prom_addr_t rd_addr,
    input  palette_pkg::prom_addr_t wr_addr,
    input  logic                    we,
    output palette_pkg::prom_data_t q
);

    // colour table, one RRRGGGBB byte per entry
    // same-address read and write in one cycle gives an undefined q
    (* ramstyle = "no_rw_check" *)
    palette_pkg::prom_data_t mem [0:palette_pkg::PROM_DEPTH-1];

    // read port
    // q only moves on a pixel enable
    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[rd_addr];
        end
    end

    // write port
    // no enable here so a download can land at any time,
    // even while the pixel enable is idle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= data;
        end
    end

endmodule

// ==== video/palette_expander.sv ====
module palette_expander (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pxl_cen,
    input  palette_pkg::prom_addr_t pix_idx,
    input  logic                    blank,
    input  logic                    prom_ready,
    input  palette_pkg::prom_data_t prom_q,
    output palette_pkg::prom_addr_t prom_rd_addr,
    output logic                    prom_cen,
    output palette_pkg::color_t     red,
    output palette_pkg::color_t     green,
    output palette_pkg::color_t     blue
);

    // stage one control, aligned with prom_q
    logic cen_d;
    logic blank_d;

    // expanded channels before gating
    palette_pkg::color_t red_x;
    palette_pkg::color_t green_x;
    palette_pkg::color_t blue_x;
    logic                force_black;

    // widen one field to a channel by repeating its bits from the top,
    // so full scale maps to all ones and zero to zero
    function automatic palette_pkg::color_t expand_field(
        input palette_pkg::prom_data_t b,
        input int                      lsb,
        input int                      width
    );
        palette_pkg::color_t c;
        for (int i = 0; i < palette_pkg::COLOR_W; i++) begin
            c[palette_pkg::COLOR_W-1-i] = b[lsb + width - 1 - (i % width)];
        end
        return c;
    endfunction

    // stage zero
    // pixel index goes straight to the prom read port
    assign prom_rd_addr = pix_idx;
    assign prom_cen = pxl_cen;

    // delay enable and blank by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            cen_d   <= 1'b0;
            blank_d <= 1'b0;
        end else begin
            cen_d <= pxl_cen;
            if (pxl_cen) begin
                blank_d <= blank;
            end
        end
    end

    // field split, RRRGGGBB
    assign red_x   = expand_field(prom_q, palette_pkg::RED_LSB, palette_pkg::RED_W);
    assign green_x = expand_field(prom_q, palette_pkg::GRN_LSB, palette_pkg::GRN_W);
    assign blue_x  = expand_field(prom_q, palette_pkg::BLU_LSB, palette_pkg::BLU_W);

    // black during blanking or without a complete table
    assign force_black = blank_d || !prom_ready;

    // stage two, output registers
    // hold between pixels
    always_ff @(posedge clk) begin
        if (reset) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (cen_d) begin
            red   <= force_black ? '0 : red_x;
            green <= force_black ? '0 : green_x;
            blue  <= force_black ? '0 : blue_x;
        end
    end

endmodule

// ==== source/palette_top.sv ====
module palette_top (
    input  logic                     clk,
    input  logic                     reset,
    // download stream from the host loader
    input  logic                     dwnld,
    input  logic                     ioctl_wr,
    input  palette_pkg::ioctl_addr_t ioctl_addr,
    input  palette_pkg::prom_data_t  ioctl_dout,
    // pixel side
    input  logic                     pxl_cen,
    input  palette_pkg::prom_addr_t  pix_idx,
    input  logic                     blank,
    output palette_pkg::color_t      red,
    output palette_pkg::color_t      green,
    output palette_pkg::color_t      blue,
    // status
    output logic                     prom_ready,
    output logic                     load_error
);

    // loader to prom write port
    logic                    prom_we;
    palette_pkg::prom_addr_t prom_wr_addr;
    palette_pkg::prom_data_t prom_wr_data;

    // expander to prom read port
    palette_pkg::prom_addr_t prom_rd_addr;
    logic                    prom_cen;
    palette_pkg::prom_data_t prom_q;

    palette_loader loader_i (
        .clk          (clk),
        .reset        (reset),
        .dwnld        (dwnld),
        .ioctl_wr     (ioctl_wr),
        .ioctl_addr   (ioctl_addr),
        .ioctl_dout   (ioctl_dout),
        .prom_we      (prom_we),
        .prom_wr_addr (prom_wr_addr),
        .prom_wr_data (prom_wr_data),
        .prom_ready   (prom_ready),
        .load_error   (load_error)
    );

    palette_prom prom_i (
        .clk     (clk),
        .cen     (prom_cen),
        .data    (prom_wr_data),
        .rd_addr (prom_rd_addr),
        .wr_addr (prom_wr_addr),
        .we      (prom_we),
        .q       (prom_q)
    );

    palette_expander expander_i (
        .clk          (clk),
        .reset        (reset),
        .pxl_cen      (pxl_cen),
        .pix_idx      (pix_idx),
        .blank        (blank),
        .prom_ready   (prom_ready),
        .prom_q       (prom_q),
        .prom_rd_addr (prom_rd_addr),
        .prom_cen     (prom_cen),
        .red          (red),
        .green        (green),
        .blue         (blue)
    );

endmodule

// ==== testbench/palette_assertions.sv ====
module palette_assertions (
    input logic                clk,
    input logic                reset,
    input logic                dwnld,
    input logic                prom_we,
    input logic                pxl_cen,
    input logic                blank,
    input logic                prom_ready,
    input logic                load_error,
    input palette_pkg::color_t red,
    input palette_pkg::color_t green,
    input palette_pkg::color_t blue
);

    timeunit 1ns;
    timeprecision 1ps;

    logic colors_zero;

    assign colors_zero = (red == '0) && (green == '0) && (blue == '0);

    // status stays clear while a download is in progress
    status_clear_in_download: assert property (
        @(posedge clk) disable iff (reset)
            (dwnld && $past(dwnld)) |-> !(prom_ready || load_error)
    ) else $error("status level high during a download");

    // a prom write trails an accepted strobe by one cycle
    write_in_download: assert property (
        @(posedge clk) disable iff (reset) prom_we |-> (dwnld || $past(dwnld))
    ) else $error("prom_we high outside a download");

    // blanked pixel shows black two cycles on
    blank_is_black: assert property (
        @(posedge clk) disable iff (reset) (pxl_cen && blank) |-> ##2 colors_zero
    ) else $error("colour not zero after a blanked pixel");

    reset_state: assert property (
        @(posedge clk) reset |=> (!prom_we && !prom_ready && !load_error && colors_zero)
    ) else $error("outputs not cleared after reset");

endmodule

bind palette_top palette_assertions assertions_i (
    .clk        (clk),
    .reset      (reset),
    .dwnld      (dwnld),
    .prom_we    (prom_we),
    .pxl_cen    (pxl_cen),
    .blank      (blank),
    .prom_ready (prom_ready),
    .load_error (load_error),
    .red        (red),
    .green      (green),
    .blue       (blue)
);

// ==== testbench/palette_tb.sv ====
module palette_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // dut ports
    logic                     clk;
    logic                     reset;
    logic                     dwnld;
    logic                     ioctl_wr;
    palette_pkg::ioctl_addr_t ioctl_addr;
    palette_pkg::prom_data_t  ioctl_dout;
    logic                     pxl_cen;
    palette_pkg::prom_addr_t  pix_idx;
    logic                     blank;
    palette_pkg::color_t      red;
    palette_pkg::color_t      green;
    palette_pkg::color_t      blue;
    logic                     prom_ready;
    logic                     load_error;

    // reference model of the colour table and the loader status
    palette_pkg::prom_data_t model_mem [0:palette_pkg::PROM_DEPTH-1];
    int   model_count;
    logic model_ready;
    logic model_error;

    // pixels in flight, each with the cycle it becomes visible
    palette_pkg::color_t exp_red_q[$];
    palette_pkg::color_t exp_green_q[$];
    palette_pkg::color_t exp_blue_q[$];
    int                  due_q[$];

    int cycle_no;
    int check_count;
    int error_count;
    int timeout_count;

    palette_top palette_top_i (
        .clk        (clk),
        .reset      (reset),
        .dwnld      (dwnld),
        .ioctl_wr   (ioctl_wr),
        .ioctl_addr (ioctl_addr),
        .ioctl_dout (ioctl_dout),
        .pxl_cen    (pxl_cen),
        .pix_idx    (pix_idx),
        .blank      (blank),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .prom_ready (prom_ready),
        .load_error (load_error)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // 3-bit field repeated from the top to fill 8 bits
    function automatic palette_pkg::color_t widen_3bit(input logic [2:0] f);
        return {f, f, f[2:1]};
    endfunction

    function automatic palette_pkg::color_t widen_2bit(input logic [1:0] f);
        return {f, f, f, f};
    endfunction

    function automatic logic in_prom_window(input palette_pkg::ioctl_addr_t a);
        return (a >= palette_pkg::PROM_START) &&
               (a < palette_pkg::PROM_START + 16'(palette_pkg::PROM_DEPTH));
    endfunction

    // address just below, just above or anywhere outside the window
    function automatic palette_pkg::ioctl_addr_t stray_addr();
        palette_pkg::ioctl_addr_t a;
        case ($urandom % 3)
            0: a = palette_pkg::PROM_START - 16'd1 - 16'($urandom % 64);
            1: a = palette_pkg::PROM_START + 16'(palette_pkg::PROM_DEPTH) + 16'($urandom % 64);
            default: a = 16'($urandom);
        endcase
        if (in_prom_window(a)) begin
            a = a ^ 16'h8000;
        end
        return a;
    endfunction

    task automatic check_color(input string name, input palette_pkg::color_t expected,
                               input palette_pkg::color_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s expected %h, actual %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s expected %b, actual %b",
                     $time, name, expected, actual);
        end
    endtask

    // one pixel clock slot, optionally with a strobe while dwnld is low
    task automatic pixel_cycle(input logic cen, input palette_pkg::prom_addr_t idx,
                               input logic blk, input logic idle_wr);
        palette_pkg::prom_data_t b;
        @(negedge clk);
        cycle_no++;
        // the pixel issued two cycles back is on the outputs now
        if (due_q.size() > 0 && due_q[0] == cycle_no) begin
            void'(due_q.pop_front());
            check_color("red", exp_red_q.pop_front(), red);
            check_color("green", exp_green_q.pop_front(), green);
            check_color("blue", exp_blue_q.pop_front(), blue);
        end
        pxl_cen = cen;
        pix_idx = idx;
        blank = blk;
        ioctl_wr = idle_wr;
        ioctl_dout = 8'($urandom);
        if ($urandom % 2 == 0) begin
            ioctl_addr = palette_pkg::PROM_START + 16'(8'($urandom));
        end else begin
            ioctl_addr = 16'($urandom);
        end
        if (cen) begin
            b = model_mem[idx];
            // black while blanking or without a full table
            if (blk || !model_ready) begin
                exp_red_q.push_back('0);
                exp_green_q.push_back('0);
                exp_blue_q.push_back('0);
            end else begin
                exp_red_q.push_back(widen_3bit(b[7:5]));
                exp_green_q.push_back(widen_3bit(b[4:2]));
                exp_blue_q.push_back(widen_2bit(b[1:0]));
            end
            due_q.push_back(cycle_no + 2);
        end
    endtask

    task automatic pixel_phase(input int cycles);
        int   burst;
        int   waited;
        logic cen;
        burst = 0;
        for (int i = 0; i < cycles; i++) begin
            // runs with the enable high every cycle
            if (burst == 0 && $urandom % 8 == 0) begin
                burst = 4 + int'($urandom % 12);
            end
            if (burst > 0) begin
                cen = 1'b1;
                burst--;
            end else begin
                cen = ($urandom % 3) == 0;
            end
            pixel_cycle(cen, 8'($urandom), ($urandom % 5) == 0, ($urandom % 6) == 0);
        end
        // drain the pipeline
        waited = 0;
        while (due_q.size() > 0 && waited < 10) begin
            pixel_cycle(1'b0, '0, 1'b0, 1'b0);
            waited++;
        end
        if (due_q.size() > 0) begin
            timeout_count++;
            $display("timeout: pixel results still pending after the last pixel");
            due_q.delete();
            exp_red_q.delete();
            exp_green_q.delete();
            exp_blue_q.delete();
        end
    endtask

    // one strobe, then zero to three idle cycles
    task automatic strobe(input palette_pkg::ioctl_addr_t addr,
                          input palette_pkg::prom_data_t data);
        int gap;
        @(negedge clk);
        ioctl_wr = 1'b1;
        ioctl_addr = addr;
        ioctl_dout = data;
        if (dwnld && in_prom_window(addr)) begin
            model_mem[8'(addr - palette_pkg::PROM_START)] = data;
            if (model_count < palette_pkg::PROM_DEPTH) begin
                model_count++;
            end
        end
        gap = ($urandom % 2 == 0) ? 0 : int'($urandom % 4);
        for (int i = 0; i < gap; i++) begin
            @(negedge clk);
            ioctl_wr = 1'b0;
        end
    endtask

    // in_count in-window bytes in shuffled order, with stray strobes mixed in
    task automatic download(input int in_count);
        palette_pkg::prom_addr_t order [0:palette_pkg::PROM_DEPTH-1];
        palette_pkg::prom_addr_t tmp;
        int                      j;
        int                      waited;
        for (int i = 0; i < palette_pkg::PROM_DEPTH; i++) begin
            order[i] = 8'(i);
        end
        for (int i = palette_pkg::PROM_DEPTH - 1; i > 0; i--) begin
            j = int'($urandom % (i + 1));
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        @(negedge clk);
        dwnld = 1'b1;
        ioctl_wr = 1'b0;
        pxl_cen = 1'b0;
        model_count = 0;
        model_ready = 1'b0;
        model_error = 1'b0;
        for (int i = 0; i < in_count; i++) begin
            while ($urandom % 3 == 0) begin
                strobe(stray_addr(), 8'($urandom));
            end
            strobe(palette_pkg::PROM_START + 16'(order[i]), 8'($urandom));
        end
        @(negedge clk);
        ioctl_wr = 1'b0;
        dwnld = 1'b0;
        model_ready = model_count >= palette_pkg::PROM_DEPTH;
        model_error = !model_ready;
        // status settles one cycle after dwnld falls
        waited = 0;
        while (!(prom_ready || load_error) && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (!(prom_ready || load_error)) begin
            timeout_count++;
            $display("timeout: loader status did not settle after the download");
        end
        check_flag("prom_ready", model_ready, prom_ready);
        check_flag("load_error", model_error, load_error);
    endtask

    initial begin
        void'($urandom(32'h2ab0));
        reset = 1'b1;
        dwnld = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        pxl_cen = 1'b0;
        pix_idx = '0;
        blank = 1'b0;
        cycle_no = 0;
        check_count = 0;
        error_count = 0;
        timeout_count = 0;
        model_count = 0;
        model_ready = 1'b0;
        model_error = 1'b0;
        for (int i = 0; i < palette_pkg::PROM_DEPTH; i++) begin
            model_mem[i] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // reset state
        @(negedge clk);
        check_flag("prom_ready", 1'b0, prom_ready);
        check_flag("load_error", 1'b0, load_error);
        check_color("red", '0, red);
        check_color("green", '0, green);
        check_color("blue", '0, blue);

        // no table yet, so every pixel is black
        pixel_phase(200);

        // full table, then colours
        download(palette_pkg::PROM_DEPTH);
        pixel_phase(2000);

        // short download fails and blacks the output
        download(1 + int'($urandom % (palette_pkg::PROM_DEPTH - 1)));
        pixel_phase(600);

        // complete reload
        download(palette_pkg::PROM_DEPTH);
        pixel_phase(2000);

        // idle strobes during the pixel phases left the status as it was
        check_flag("prom_ready", model_ready, prom_ready);
        check_flag("load_error", model_error, load_error);

        $display("checks: %0d, mismatches: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
common/palette_pkg.sv
source/palette_loader.sv
video/palette_prom.sv
video/palette_expander.sv
source/palette_top.sv
testbench/palette_assertions.sv
testbench/palette_tb.sv

// ==== Makefile ====
# Verilator build for the colour path testbench

VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
TOP        = palette_tb
FILELIST   = files.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = Testbench failed
PASS_MSG   = Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi
	@echo "simulation ok"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
